// ==== build.f ====
+incdir+.
decodePkg.sv
opcodeCapture.sv
entryMatch.sv
controlSelect.sv
decodeTop.sv
decodeTb.sv

// ==== controlSelect.sv ====
`timescale 1ns/1ps

module controlSelect (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              matchValid,
  input  logic [decodePkg::NumEntries-1:0]  hitVector,
  input  decodePkg::modrmByte               matchModrm,
  output logic                              ctrlValid,
  output logic [decodePkg::CtrlWidth-1:0]   ctrlWord,
  output logic                              ctrlMiss,
  output logic [1:0]                        addrMod,
  output logic [2:0]                        addrRm
);

  import decodePkg::*;

  logic [CtrlWidth-1:0] selWord;
  logic                 selMiss;

  // ##############################
  // priority select
  // ##############################

  // walk from the top down so the lowest set index is the last write.
  always_comb begin
    selWord = FaultWord;                            // no entry, trap.
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (hitVector[i]) begin
        selWord = entryCtrl[i];
      end
    end
  end

  assign selMiss = ~|hitVector;

  // ##############################
  // output register
  // ##############################

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlValid <= 1'b0;
      ctrlMiss  <= 1'b0;
    end else begin
      ctrlValid <= matchValid;
      if (matchValid) begin
        ctrlMiss <= selMiss;                        // held through gaps.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (matchValid) begin
      ctrlWord <= selWord;
      addrMod  <= matchModrm.fields.mod;            // to address generation.
      addrRm   <= matchModrm.fields.rm;
    end
  end

endmodule

// ==== controlTable.svh ====
`ifndef CONTROL_TABLE_SVH
`define CONTROL_TABLE_SVH

// entries are in priority order, index 0 wins over any later hit.
// 0-8: add/or/and groups, 9-11: ff group, 12-15 and 29-30: shifts,
// 16-21, 27-28: mov, 22-25: jmp/call/ret, 26 and 31: two-byte escape.

localparam logic [7:0] entryOpcode [NumEntries] = '{
  8'h80, 8'h81, 8'h83, 8'h80, 8'h81, 8'h83, 8'h80, 8'h81,
  8'h83, 8'hFF, 8'hFF, 8'hFF, 8'hD1, 8'hD1, 8'hC1, 8'hC1,
  8'h88, 8'h89, 8'h8A, 8'h8B, 8'hC6, 8'hC7, 8'hE9, 8'hEB,
  8'hE8, 8'hC3, 8'h0F, 8'h8C, 8'h8E, 8'hD3, 8'hD3, 8'h0F
};

// set where the entry needs modrm.reg as well.
localparam logic entryUsesReg [NumEntries] = '{
  1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
  1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0
};

// don't care where entryUsesReg is clear.
localparam logic [2:0] entryReg [NumEntries] = '{
  3'd0, 3'd0, 3'd0, 3'd1, 3'd1, 3'd1, 3'd4, 3'd4,
  3'd4, 3'd2, 3'd4, 3'd6, 3'd4, 3'd7, 3'd4, 3'd7,
  3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0,
  3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd4, 3'd7, 3'd0
};

// upper half is the uop class, lower half the microcode address.
localparam logic [CtrlWidth-1:0] entryCtrl [NumEntries] = '{
  32'h0011_0100, 32'h0012_0104, 32'h0013_0108, 32'h0021_0110,
  32'h0022_0114, 32'h0023_0118, 32'h0031_0120, 32'h0032_0124,
  32'h0033_0128, 32'h0041_0130, 32'h0042_0134, 32'h0043_0138,
  32'h0051_0140, 32'h0052_0144, 32'h0053_0148, 32'h0054_014C,
  32'h0061_0200, 32'h0062_0204, 32'h0063_0208, 32'h0064_020C,
  32'h0065_0210, 32'h0066_0214, 32'h0071_0300, 32'h0072_0304,
  32'h0073_0308, 32'h0074_030C, 32'h0081_0400, 32'h0067_0218,
  32'h0068_021C, 32'h0055_0150, 32'h0056_0154, 32'h0082_0404
};

`endif

// ==== decodePkg.sv ====
package decodePkg;

  // ##############################
  // table geometry
  // ##############################

  localparam int NumEntries = 32;                   // control-store entries.
  localparam int CtrlWidth  = 32;                   // control word bits.

  // invalid-opcode trap, microcode vector 6.
  localparam logic [CtrlWidth-1:0] FaultWord = 32'h8000_0006;

  // ##############################
  // modrm byte
  // ##############################

  // the reg/opcode field picks the operation inside a group opcode,
  // while mod and rm go on to address generation.
  typedef union packed {
    logic [7:0] raw;                                // byte as fetched.
    struct packed {
      logic [1:0] mod;                              // addressing mode.
      logic [2:0] regOp;                            // reg or group extension.
      logic [2:0] rm;                               // base register / memory form.
    } fields;
  } modrmByte;

  // ##############################
  // control store
  // ##############################

  `include "controlTable.svh"

endpackage

// ==== decodeTb.sv ====
`timescale 1ns/1ps

module decodeTb;

  import decodePkg::*;

  localparam int NumCycles   = 400;                 // random stimulus cycles.
  localparam int DirectedLen = 9;                   // directed cycles, gap included.
  localparam int TestLength  = NumCycles + DirectedLen;

  typedef struct packed {
    logic [CtrlWidth-1:0] word;
    logic                 miss;
    logic [1:0]           mod;
    logic [2:0]           rm;
    int                   dueEdge;                  // edge count when ctrlValid shows it.
  } expectEntry;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 instrValid;
  logic [7:0]           opcode;
  modrmByte             modrm;
  logic                 ctrlValid;
  logic [CtrlWidth-1:0] ctrlWord;
  logic                 ctrlMiss;
  logic [1:0]           addrMod;
  logic [2:0]           addrRm;

  integer     seed = 68850;
  int         edgeCount = 0;
  expectEntry expQ [$];
  expectEntry cur;
  expectEntry last;
  logic       seenResult = 1'b0;

  decodeTop UUT (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .opcode     (opcode),
    .modrm      (modrm),
    .ctrlValid  (ctrlValid),
    .ctrlWord   (ctrlWord),
    .ctrlMiss   (ctrlMiss),
    .addrMod    (addrMod),
    .addrRm     (addrRm)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
  end

  // ##############################
  // model and checks
  // ##############################

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "decode testbench stopped");
  endtask

  // first matching entry in table order wins.
  function automatic expectEntry modelResult(input logic [7:0] op, input modrmByte m,
                                             input int due);
    expectEntry e;
    logic       found;
    e.word = FaultWord;
    e.miss = 1'b1;
    found  = 1'b0;
    for (int i = 0; i < NumEntries; i++) begin
      if (!found && op == entryOpcode[i] &&
          (!entryUsesReg[i] || m.fields.regOp == entryReg[i])) begin
        found  = 1'b1;
        e.word = entryCtrl[i];
        e.miss = 1'b0;
      end
    end
    e.mod     = m.fields.mod;
    e.rm      = m.fields.rm;
    e.dueEdge = due;
    return e;
  endfunction

  task automatic checkCtrl(input logic [CtrlWidth-1:0] gotWord, input logic gotMiss,
                           input logic [CtrlWidth-1:0] expWord, input logic expMiss);
    if (gotWord !== expWord) begin
      abortRun($sformatf("CHECK FAILED ctrlWord got %h expected %h", gotWord, expWord));
    end
    if (gotMiss !== expMiss) begin
      abortRun($sformatf("CHECK FAILED ctrlMiss got %h expected %h", gotMiss, expMiss));
    end
  endtask

  task automatic checkModrm(input modrmByte got, input modrmByte exp);
    if (got.fields.mod !== exp.fields.mod) begin
      abortRun($sformatf("CHECK FAILED addrMod got %h expected %h",
                         got.fields.mod, exp.fields.mod));
    end
    if (got.fields.rm !== exp.fields.rm) begin
      abortRun($sformatf("CHECK FAILED addrRm got %h expected %h",
                         got.fields.rm, exp.fields.rm));
    end
  endtask

  task automatic checkAddr(input expectEntry e);
    modrmByte got;
    modrmByte exp;
    got.raw        = 8'h00;                         // reg field is not carried out.
    got.fields.mod = addrMod;
    got.fields.rm  = addrRm;
    exp.raw        = 8'h00;
    exp.fields.mod = e.mod;
    exp.fields.rm  = e.rm;
    checkModrm(got, exp);
  endtask

  // outputs settle after the rising edge so look at the falling one.
  always @(negedge clk) begin
    if (ctrlValid === 1'b1) begin
      if (expQ.size() == 0) begin
        abortRun("ctrlValid went high with no instruction outstanding");
      end
      cur = expQ.pop_front();
      if (edgeCount != cur.dueEdge) begin
        abortRun($sformatf("result arrived at edge %0d but was due at edge %0d",
                           edgeCount, cur.dueEdge));
      end
      checkCtrl(ctrlWord, ctrlMiss, cur.word, cur.miss);
      checkAddr(cur);
      last       = cur;
      seenResult = 1'b1;
    end else if (ctrlValid !== 1'b0) begin
      abortRun("ctrlValid is unknown");
    end else begin
      if (expQ.size() != 0 && expQ[0].dueEdge <= edgeCount) begin
        abortRun("an expected result did not appear in its cycle");
      end
      if (!seenResult) begin
        if (ctrlMiss !== 1'b0) begin
          abortRun("ctrlMiss is not low before the first result");
        end
      end else begin
        checkCtrl(ctrlWord, ctrlMiss, last.word, last.miss);   // held in gaps.
        checkAddr(last);
      end
    end
  end

  // ##############################
  // stimulus
  // ##############################

  task automatic sendInstr(input logic [7:0] op, input modrmByte m);
    @(posedge clk);
    instrValid <= 1'b1;
    opcode     <= op;
    modrm      <= m;
    expQ.push_back(modelResult(op, m, edgeCount + 4));
  endtask

  task automatic idleCycle();
    int r;
    r = $random(seed);
    @(posedge clk);
    instrValid <= 1'b0;
    opcode     <= r[7:0];                           // junk the DUT must ignore.
    modrm      <= r[15:8];
  endtask

  task automatic sendRandom();
    int r;
    int idx;
    r   = $random(seed);
    idx = $unsigned($random(seed)) % NumEntries;
    if (r[16]) begin
      sendInstr(entryOpcode[idx], r[15:8]);         // table opcode for frequent hits.
    end else begin
      sendInstr(r[7:0], r[15:8]);
    end
  endtask

  initial begin
    int r;
    reset      = 1'b1;
    instrValid = 1'b0;
    opcode     = 8'h00;
    modrm      = 8'h00;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    sendInstr(8'h0F, 8'hC0);                        // duplicate resolved to entry 26.
    sendInstr(8'h81, 8'hD9);                        // group 81 /3 has no entry.
    sendInstr(8'hFF, 8'h05);                        // group ff /0 has no entry.
    sendInstr(8'h89, 8'h45);
    sendInstr(8'hE8, 8'hFF);
    idleCycle();
    sendInstr(8'hC3, 8'h3C);
    sendInstr(8'hD1, 8'h7A);                        // shift /7.
    sendInstr(8'hC1, 8'hA6);                        // shift /4.
    for (int t = 0; t < NumCycles; t++) begin
      r = $random(seed);
      if (r[1:0] != 2'b00) begin
        sendRandom();
      end else begin
        idleCycle();
      end
    end
    idleCycle();
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);                      // no stray result after the last one.
    $display("TEST RESULT: PASS");
    $finish;
  end

  // ##############################
  // watchdog
  // ##############################

  initial begin
    #((TestLength + 20) * 100 * 2);
    abortRun("timeout, the decoder did not finish in time");
  end

endmodule

// ==== decodeTop.sv ====
`timescale 1ns/1ps

module decodeTop (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              instrValid,
  input  logic [7:0]                        opcode,
  input  decodePkg::modrmByte               modrm,
  output logic                              ctrlValid,
  output logic [decodePkg::CtrlWidth-1:0]   ctrlWord,
  output logic                              ctrlMiss,
  output logic [1:0]                        addrMod,
  output logic [2:0]                        addrRm
);

  import decodePkg::*;

  // stage 1 to stage 2.
  logic                  capValid;
  logic [7:0]            capOpcode;
  modrmByte              capModrm;

  // stage 2 to stage 3.
  logic                  matchValid;
  logic [NumEntries-1:0] hitVector;
  modrmByte              matchModrm;

  opcodeCapture capture (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .opcode     (opcode),
    .modrm      (modrm),
    .capValid   (capValid),
    .capOpcode  (capOpcode),
    .capModrm   (capModrm)
  );

  entryMatch match (
    .clk        (clk),
    .reset      (reset),
    .capValid   (capValid),
    .capOpcode  (capOpcode),
    .capModrm   (capModrm),
    .matchValid (matchValid),
    .hitVector  (hitVector),
    .matchModrm (matchModrm)
  );

  controlSelect select (
    .clk        (clk),
    .reset      (reset),
    .matchValid (matchValid),
    .hitVector  (hitVector),
    .matchModrm (matchModrm),
    .ctrlValid  (ctrlValid),
    .ctrlWord   (ctrlWord),
    .ctrlMiss   (ctrlMiss),
    .addrMod    (addrMod),
    .addrRm     (addrRm)
  );

endmodule

// ==== entryMatch.sv ====
`timescale 1ns/1ps

module entryMatch (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              capValid,
  input  logic [7:0]                        capOpcode,
  input  decodePkg::modrmByte               capModrm,
  output logic                              matchValid,
  output logic [decodePkg::NumEntries-1:0]  hitVector,
  output decodePkg::modrmByte               matchModrm
);

  import decodePkg::*;

  logic [NumEntries-1:0] hitNext;
  logic [2:0]            regOp;

  assign regOp = capModrm.fields.regOp;             // group extension.

  // ##############################
  // comparator bank
  // ##############################

  // every entry is checked in parallel, priority is resolved downstream.
  always_comb begin
    for (int i = 0; i < NumEntries; i++) begin
      hitNext[i] = (capOpcode == entryOpcode[i]) &&
                   (!entryUsesReg[i] || (regOp == entryReg[i]));
    end
  end

  // ##############################
  // stage register
  // ##############################

  always_ff @(posedge clk) begin
    if (reset) begin
      matchValid <= 1'b0;
    end else begin
      matchValid <= capValid;
    end
  end

  always_ff @(posedge clk) begin
    if (capValid) begin
      hitVector  <= hitNext;
      matchModrm <= capModrm;                       // carried for mod/rm.
    end
  end

endmodule

// ==== opcodeCapture.sv ====
`timescale 1ns/1ps

module opcodeCapture (
  input  logic              clk,
  input  logic              reset,
  input  logic              instrValid,
  input  logic [7:0]        opcode,
  input  decodePkg::modrmByte modrm,
  output logic              capValid,
  output logic [7:0]        capOpcode,
  output decodePkg::modrmByte capModrm
);

  // ##############################
  // strobe
  // ##############################

  always_ff @(posedge clk) begin
    if (reset) begin
      capValid <= 1'b0;
    end else begin
      capValid <= instrValid;                       // one instruction per cycle.
    end
  end

  // ##############################
  // bytes
  // ##############################

  // the bytes only move with the strobe, so a gap leaves them steady.
  always_ff @(posedge clk) begin
    if (instrValid) begin
      capOpcode <= opcode;
      capModrm  <= modrm;                           // raw byte, fields decoded later.
    end
  end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# compile and run the decoder testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -j 0 --top-module decodeTb -f build.f -o decodeSim > sim.log 2>&1 \
  || { cat sim.log; echo "compile step failed"; exit 1; }
./obj_dir/decodeSim >> sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in log"; exit 1; }
exit 0
